// File: logic/icache_consts.svh
// icache geometry constants and the filler word for an unused fetch slot
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// 16 sets
`define ICACHE_INDEX_W   4
`define ICACHE_SETS      (1 << `ICACHE_INDEX_W)

// four 32-bit words per line
`define ICACHE_OFFSET_W  2

// lru logic assumes exactly two ways
`define ICACHE_WAYS      2

// address bits above index, word offset and byte offset
`define ICACHE_TAG_W     (32 - `ICACHE_INDEX_W - `ICACHE_OFFSET_W - 2)
`define ICACHE_LINE_W    (32 << `ICACHE_OFFSET_W)

`define ICACHE_FILL_WORD 32'h1234abcd

`endif

// File: logic/icache_pkg.sv
// icache types shared by the fetch interface, the controller and the arrays
`include "icache_consts.svh"

package icache_pkg;

    ////////////////////////////////////////
    // opcodes and controller states
    ////////////////////////////////////////

    typedef enum logic [0:0] {
        op_fetch,
        op_inv_index
    } icache_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_miss_req,
        st_miss_wait
    } icache_state_e;

    ////////////////////////////////////////
    // fetch and memory payloads
    ////////////////////////////////////////

    typedef struct packed {
        logic [31:0] addr;
        icache_op_e  op;
    } fetch_req_t;

    // insn[31:0] is the addressed word, insn[63:32] the next one
    typedef struct packed {
        logic [31:0] pc;
        logic [63:0] insn;
        logic        pair_valid;
    } fetch_resp_t;

    typedef logic [`ICACHE_LINE_W-1:0] mem_line_t;

endpackage

// File: logic/icache_req_buf.sv
// icache request buffer, keeps the accepted request through lookup and refill
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_req_buf import icache_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       we,
    input  fetch_req_t req,
    output fetch_req_t buf_req
);

    fetch_req_t req_q;

    // written once per accepted request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= '0;
        end else if (we) begin
            req_q <= req;
        end
    end

    // tag, index and pc all come from here until the next accept
    assign buf_req = req_q;

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // the pipeline must hand over a fully defined request
    a_req_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        we |-> !$isunknown(req)
    );

endmodule

// File: logic/icache_arrays.sv
// icache storage, tag and data per way with valid and lru bits per set
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_arrays import icache_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               rd_en,
    input  logic [`ICACHE_INDEX_W-1:0]         rd_index,
    input  logic [`ICACHE_TAG_W-1:0]           cmp_tag,
    output logic [`ICACHE_WAYS-1:0]            hit,
    output mem_line_t [`ICACHE_WAYS-1:0]       way_lines,
    output logic                               victim_way,
    input  logic [`ICACHE_INDEX_W-1:0]         wr_index,
    input  logic                               fill_we,
    input  logic                               fill_way,
    input  mem_line_t                          fill_line,
    input  logic                               inv_we,
    input  logic                               touch,
    input  logic                               touch_way
);

    logic [`ICACHE_WAYS-1:0]    valid_q [`ICACHE_SETS];
    // most recently used way per set
    logic [`ICACHE_SETS-1:0]    lru_q;
    logic [`ICACHE_INDEX_W-1:0] rd_index_q;

    ////////////////////////////////////////
    // per-way tag and data
    ////////////////////////////////////////

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_SETS];
        mem_line_t                data_mem [`ICACHE_SETS];
        logic [`ICACHE_TAG_W-1:0] tag_q;
        mem_line_t                line_q;

        // a fill also loads the read registers, so a deferred answer can hit
        always_ff @(posedge clk) begin
            if (fill_we && fill_way == 1'(w)) begin
                tag_mem[wr_index]  <= cmp_tag;
                data_mem[wr_index] <= fill_line;
                tag_q              <= cmp_tag;
                line_q             <= fill_line;
            end else if (rd_en) begin
                tag_q  <= tag_mem[rd_index];
                line_q <= data_mem[rd_index];
            end
        end

        assign hit[w]       = valid_q[rd_index_q][w] && (tag_q == cmp_tag);
        assign way_lines[w] = line_q;
    end

    ////////////////////////////////////////
    // valid and lru state
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid_q[s] <= '0;
            end
            lru_q      <= '0;
            rd_index_q <= '0;
        end else begin
            if (rd_en) begin
                rd_index_q <= rd_index;
            end
            if (inv_we) begin
                valid_q[wr_index] <= '0;
            end else if (fill_we) begin
                valid_q[wr_index][fill_way] <= 1'b1;
            end
            if (touch) begin
                lru_q[wr_index] <= touch_way;
            end
        end
    end

    // empty way first, else the one not used last
    always_comb begin
        if (!valid_q[rd_index_q][0]) begin
            victim_way = 1'b0;
        end else if (!valid_q[rd_index_q][1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = ~lru_q[rd_index_q];
        end
    end

    a_hit_onehot : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(&hit)
    );

endmodule

// File: logic/icache_ctrl.sv
// icache controller FSM for lookup, line refill, index invalidate and stall
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_ctrl import icache_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic                    stall,
    input  fetch_req_t              buf_req,
    input  logic [`ICACHE_WAYS-1:0] hit,
    input  logic                    victim_way,
    output logic                    buf_we,
    output logic                    rd_en,
    output logic                    fill_we,
    output logic                    fill_way,
    output logic                    inv_we,
    output logic                    touch,
    output logic                    touch_way,
    output logic                    mem_req,
    output logic [31:0]             mem_addr,
    input  logic                    mem_addr_ok,
    input  logic                    mem_data_ok,
    output logic                    sel_return,
    output logic                    sel_way,
    output logic                    resp_fire,
    output logic                    hold
);

    icache_state_e state, state_nxt;
    logic          accept;
    logic          is_inv;

    assign is_inv = (buf_req.op == op_inv_index);

    // a hit or an invalidate in lookup frees the slot for the next request
    assign req_ready = !stall && (state == st_idle ||
                       (state == st_lookup && (is_inv || (|hit))));
    assign accept    = req_valid && req_ready;
    assign buf_we    = accept;
    assign rd_en     = accept;

    assign mem_addr   = {buf_req.addr[31:`ICACHE_OFFSET_W+2], {(`ICACHE_OFFSET_W+2){1'b0}}};
    assign sel_return = (state == st_miss_wait);
    assign sel_way    = hit[1];
    assign fill_way   = victim_way;
    assign hold       = stall;

    always_comb begin
        state_nxt = state;
        mem_req   = 1'b0;
        fill_we   = 1'b0;
        inv_we    = 1'b0;
        touch     = 1'b0;
        touch_way = hit[1];
        resp_fire = 1'b0;
        case (state)
            st_idle: begin
                if (accept) state_nxt = st_lookup;
            end
            st_lookup: begin
                if (is_inv) begin
                    inv_we    = 1'b1;
                    state_nxt = accept ? st_lookup : st_idle;
                end else if (|hit) begin
                    // hit waits here while stalled
                    if (!stall) begin
                        resp_fire = 1'b1;
                        touch     = 1'b1;
                        state_nxt = accept ? st_lookup : st_idle;
                    end
                end else begin
                    state_nxt = st_miss_req;
                end
            end
            st_miss_req: begin
                mem_req = 1'b1;
                if (mem_addr_ok) state_nxt = st_miss_wait;
            end
            st_miss_wait: begin
                if (mem_data_ok) begin
                    fill_we   = 1'b1;
                    touch     = 1'b1;
                    touch_way = victim_way;
                    // under stall, answer later from the refilled way
                    if (!stall) begin
                        resp_fire = 1'b1;
                        state_nxt = st_idle;
                    end else begin
                        state_nxt = st_lookup;
                    end
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // memory may only take an address that is being offered
    a_addr_ok_with_req : assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_addr_ok |-> mem_req
    );

    // line data only for the single outstanding refill
    a_data_ok_in_wait : assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_data_ok |-> state == st_miss_wait
    );

endmodule

// File: logic/icache_fetch_out.sv
// icache response stage, picks the line and word pair and holds it on stall
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_fetch_out import icache_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  fetch_req_t                   buf_req,
    input  mem_line_t [`ICACHE_WAYS-1:0] way_lines,
    input  mem_line_t                    mem_line,
    input  logic                         sel_return,
    input  logic                         sel_way,
    input  logic                         resp_fire,
    input  logic                         hold,
    output fetch_resp_t                  resp,
    output logic                         resp_valid
);

    mem_line_t                  line;
    logic [`ICACHE_OFFSET_W-1:0] offset;
    fetch_resp_t                resp_now;
    fetch_resp_t                resp_q;

    assign offset = buf_req.addr[`ICACHE_OFFSET_W+1:2];

    // refill data passes straight through
    always_comb begin
        line        = sel_return ? mem_line : way_lines[sel_way];
        resp_now.pc = buf_req.addr;
        if (!offset[0]) begin
            resp_now.insn       = line[{offset, 5'd0} +: 64];
            resp_now.pair_valid = 1'b1;
        end else begin
            resp_now.insn       = {`ICACHE_FILL_WORD, line[{offset, 5'd0} +: 32]};
            resp_now.pair_valid = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_q <= '0;
        end else if (resp_fire) begin
            resp_q <= resp_now;
        end
    end

    assign resp       = hold ? resp_q : resp_now;
    assign resp_valid = resp_fire;

endmodule

// File: logic/icache.sv
// icache top, two-way set-associative instruction cache for dual-issue fetch
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  fetch_req_t  req,
    input  logic        req_valid,
    output logic        req_ready,
    input  logic        stall,
    output fetch_resp_t resp,
    output logic        resp_valid,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    input  logic        mem_addr_ok,
    input  mem_line_t   mem_line,
    input  logic        mem_data_ok
);

    fetch_req_t                   buf_req;
    logic                         buf_we;
    logic                         rd_en;
    logic [`ICACHE_WAYS-1:0]      hit;
    mem_line_t [`ICACHE_WAYS-1:0] way_lines;
    logic                         victim_way;
    logic                         fill_we;
    logic                         fill_way;
    logic                         inv_we;
    logic                         touch;
    logic                         touch_way;
    logic                         sel_return;
    logic                         sel_way;
    logic                         resp_fire;
    logic                         hold;

    icache_req_buf req_buf_inst (
        .clk(clk), .rst_n(rst_n),
        .we(buf_we), .req(req), .buf_req(buf_req)
    );

    // read index from the incoming request, everything else from the buffer
    icache_arrays arrays_inst (
        .clk(clk), .rst_n(rst_n),
        .rd_en(rd_en),
        .rd_index(req.addr[`ICACHE_OFFSET_W+`ICACHE_INDEX_W+1:`ICACHE_OFFSET_W+2]),
        .cmp_tag(buf_req.addr[31 -: `ICACHE_TAG_W]),
        .hit(hit), .way_lines(way_lines), .victim_way(victim_way),
        .wr_index(buf_req.addr[`ICACHE_OFFSET_W+`ICACHE_INDEX_W+1:`ICACHE_OFFSET_W+2]),
        .fill_we(fill_we), .fill_way(fill_way), .fill_line(mem_line),
        .inv_we(inv_we), .touch(touch), .touch_way(touch_way)
    );

    icache_ctrl ctrl_inst (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .stall(stall),
        .buf_req(buf_req), .hit(hit), .victim_way(victim_way),
        .buf_we(buf_we), .rd_en(rd_en), .fill_we(fill_we), .fill_way(fill_way),
        .inv_we(inv_we), .touch(touch), .touch_way(touch_way),
        .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .sel_return(sel_return), .sel_way(sel_way),
        .resp_fire(resp_fire), .hold(hold)
    );

    icache_fetch_out fetch_out_inst (
        .clk(clk), .rst_n(rst_n),
        .buf_req(buf_req), .way_lines(way_lines), .mem_line(mem_line),
        .sel_return(sel_return), .sel_way(sel_way),
        .resp_fire(resp_fire), .hold(hold),
        .resp(resp), .resp_valid(resp_valid)
    );

endmodule

// File: sim/tb_mem_model.sv
// line memory model for icache refills, random handshake latency and a request counter
`timescale 1ns/1ns
`include "icache_consts.svh"

module tb_mem_model import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_req,
    input  logic [31:0] mem_addr,
    output logic        mem_addr_ok,
    output mem_line_t   mem_line,
    output logic        mem_data_ok,
    output integer      req_count
);

    typedef enum logic [1:0] {
        ph_idle,
        ph_addr_wait,
        ph_granted,
        ph_data_wait
    } mem_phase_e;

    mem_phase_e  phase;
    integer      seed = 32'h1f0ab840;
    integer      delay;
    logic [31:0] line_addr;

    // word w of memory holds w xor 5a5a0000, lowest word in the low bits
    function automatic mem_line_t line_at(input logic [31:0] addr);
        mem_line_t line;
        for (int i = 0; i < (1 << `ICACHE_OFFSET_W); i++) begin
            line[32*i +: 32] = ((addr >> 2) + i) ^ 32'h5a5a0000;
        end
        return line;
    endfunction

    // outputs move on the falling edge only
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= ph_idle;
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_line    <= '0;
            req_count   <= 0;
            delay       <= 0;
            line_addr   <= '0;
        end else begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            case (phase)
                ph_idle: begin
                    if (mem_req) begin
                        line_addr <= mem_addr;
                        delay     <= $unsigned($random(seed)) % 4;
                        phase     <= ph_addr_wait;
                    end
                end
                ph_addr_wait: begin
                    if (delay == 0) begin
                        mem_addr_ok <= 1'b1;
                        phase       <= ph_granted;
                    end else begin
                        delay <= delay - 1;
                    end
                end
                // address taken at the rising edge just passed
                ph_granted: begin
                    req_count <= req_count + 1;
                    delay     <= $unsigned($random(seed)) % 4;
                    phase     <= ph_data_wait;
                end
                default: begin
                    if (delay == 0) begin
                        mem_data_ok <= 1'b1;
                        mem_line    <= line_at(line_addr);
                        phase       <= ph_idle;
                    end else begin
                        delay <= delay - 1;
                    end
                end
            endcase
        end
    end

endmodule

// File: sim/tb_icache.sv
// testbench for the icache, table of fetches and invalidates against a memory model
`timescale 1ns/1ns
`include "icache_consts.svh"

module tb_icache import icache_pkg::*; ();

    localparam int n_rows  = 14;
    localparam int n_burst = 4;
    localparam int limit   = (n_rows + n_burst) * 20 + 8;

    typedef struct packed {
        icache_op_e  op;
        logic [31:0] addr;
        logic [3:0]  stall_cycles;
        logic        miss;
    } test_row_t;

    logic        clk;
    logic        rst_n;
    fetch_req_t  req;
    logic        req_valid;
    logic        req_ready;
    logic        stall;
    fetch_resp_t resp;
    logic        resp_valid;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_addr_ok;
    mem_line_t   mem_line;
    logic        mem_data_ok;
    integer      req_count;
    integer      cycles = 0;
    test_row_t   rows [n_rows];
    logic [31:0] burst_addr [n_burst];
    fetch_resp_t last_resp;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    icache icache_inst (
        .clk(clk), .rst_n(rst_n),
        .req(req), .req_valid(req_valid), .req_ready(req_ready), .stall(stall),
        .resp(resp), .resp_valid(resp_valid),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_addr_ok(mem_addr_ok),
        .mem_line(mem_line), .mem_data_ok(mem_data_ok)
    );

    tb_mem_model mem_inst (
        .clk(clk), .rst_n(rst_n),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_addr_ok(mem_addr_ok),
        .mem_line(mem_line), .mem_data_ok(mem_data_ok), .req_count(req_count)
    );

    ////////////////////////////////////////
    // expected values and checks
    ////////////////////////////////////////

    // addressed word low, next word or filler above it
    function automatic fetch_resp_t expected_resp(input logic [31:0] addr);
        fetch_resp_t r;
        logic [31:0] w;
        w             = addr >> 2;
        r.pc          = addr;
        r.pair_valid  = !addr[2];
        r.insn[31:0]  = w ^ 32'h5a5a0000;
        r.insn[63:32] = addr[2] ? `ICACHE_FILL_WORD : ((w + 1) ^ 32'h5a5a0000);
        return r;
    endfunction

    task automatic report_failure();
        $display("Regression failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic compare_resp(input fetch_resp_t got, input fetch_resp_t exp,
                                input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is pc %h insn %h pair %b, expected pc %h insn %h pair %b",
                     $time, what, got.pc, got.insn, got.pair_valid,
                     exp.pc, exp.insn, exp.pair_valid);
            report_failure();
        end
    endtask

    task automatic compare_count(input integer got, input integer exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            report_failure();
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("the cache never answered within %0d cycles", limit);
            report_failure();
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    // A, B and C share set 3, D sits in set 5
    task automatic load_table();
        rows[0]  = '{op_fetch,     32'h0000_1030, 4'd0, 1'b1};
        rows[1]  = '{op_fetch,     32'h0000_103c, 4'd0, 1'b0};
        rows[2]  = '{op_fetch,     32'h0000_1034, 4'd0, 1'b0};
        rows[3]  = '{op_fetch,     32'h0000_4058, 4'd0, 1'b1};
        rows[4]  = '{op_fetch,     32'h0000_2034, 4'd0, 1'b1};
        rows[5]  = '{op_fetch,     32'h0000_1038, 4'd0, 1'b0};
        // C evicts B, the least recently used way
        rows[6]  = '{op_fetch,     32'h0000_3030, 4'd0, 1'b1};
        rows[7]  = '{op_fetch,     32'h0000_1030, 4'd0, 1'b0};
        rows[8]  = '{op_fetch,     32'h0000_2038, 4'd0, 1'b1};
        rows[9]  = '{op_inv_index, 32'h0000_1030, 4'd0, 1'b0};
        rows[10] = '{op_fetch,     32'h0000_1034, 4'd0, 1'b1};
        rows[11] = '{op_fetch,     32'h0000_4050, 4'd0, 1'b0};
        // stalled hit, then stalled miss
        rows[12] = '{op_fetch,     32'h0000_405c, 4'd4, 1'b0};
        rows[13] = '{op_fetch,     32'h0000_3038, 4'd6, 1'b1};
        burst_addr[0] = 32'h0000_1030;
        burst_addr[1] = 32'h0000_103c;
        burst_addr[2] = 32'h0000_4054;
        burst_addr[3] = 32'h0000_3034;
    endtask

    // drive on the falling edge, sample 1 ns before the rising edge
    task automatic apply_row(input test_row_t row);
        integer base;
        base = req_count;
        @(negedge clk);
        req       = '{addr: row.addr, op: row.op};
        req_valid = 1'b1;
        #4;
        while (!req_ready) begin
            @(negedge clk);
            #4;
        end
        @(negedge clk);
        req_valid = 1'b0;
        for (int k = 0; k < row.stall_cycles; k++) begin
            stall = 1'b1;
            #4;
            compare_flag(req_ready, 1'b0, "req_ready under stall");
            compare_flag(resp_valid, 1'b0, "resp_valid under stall");
            compare_resp(resp, last_resp, "held resp");
            @(negedge clk);
        end
        stall = 1'b0;
        #4;
        if (row.op == op_inv_index) begin
            compare_flag(resp_valid, 1'b0, "resp_valid after invalidate");
        end else begin
            // a hit answers in the lookup cycle or right after stall
            if (!row.miss) begin
                compare_flag(resp_valid, 1'b1, "resp_valid of a hit");
            end
            while (!resp_valid) begin
                @(negedge clk);
                #4;
            end
            compare_resp(resp, expected_resp(row.addr), "resp");
            last_resp = expected_resp(row.addr);
        end
        compare_count(req_count - base, row.miss, "memory requests of the row");
    endtask

    // one hit request per cycle, each answered in the next cycle
    task automatic run_burst();
        integer base;
        base = req_count;
        for (int i = 0; i <= n_burst; i++) begin
            @(negedge clk);
            req_valid = (i < n_burst);
            if (i < n_burst) begin
                req = '{addr: burst_addr[i], op: op_fetch};
            end
            #4;
            if (i < n_burst) begin
                compare_flag(req_ready, 1'b1, "req_ready in burst");
            end
            if (i > 0) begin
                compare_flag(resp_valid, 1'b1, "resp_valid in burst");
                compare_resp(resp, expected_resp(burst_addr[i-1]), "burst resp");
            end
        end
        compare_count(req_count - base, 0, "memory requests of the burst");
    endtask

    initial begin
        rst_n     = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        stall     = 1'b0;
        last_resp = '0;
        load_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #4;
        compare_flag(req_ready, 1'b1, "req_ready after reset");
        compare_flag(resp_valid, 1'b0, "resp_valid after reset");
        compare_flag(mem_req, 1'b0, "mem_req after reset");
        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);
        end
        run_burst();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: icache.f
+incdir+logic
logic/icache_pkg.sv
logic/icache_req_buf.sv
logic/icache_arrays.sv
logic/icache_ctrl.sv
logic/icache_fetch_out.sv
logic/icache.sv
sim/tb_mem_model.sv
sim/tb_icache.sv
